/* verilog.f */
+incdir+bench
verilog/itlb_pkg.sv
verilog/tlb_lookup_if.sv
verilog/tlb_fill_if.sv
verilog/tlb_array.sv
verilog/itlb_miss_unit.sv
verilog/itlb_top.sv
bench/itlb_tb.sv

/* Makefile */
TOP = itlb_tb

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* bench/itlb_tests.svh */
// ----------------------------------------------------------------------
// stimulus helpers.
// ----------------------------------------------------------------------
function automatic vaddr_t make_va(input logic [9:0] vpn1, input logic [9:0] vpn0,
                                   input page_off_t off);
    return {vpn1, vpn0, off};
endfunction

function automatic tlb_entry_t make_entry(input logic mega, input logic exec);
    tlb_entry_t e;
    e = '0;
    e.ppn.ppn1 = 12'($urandom);
    e.ppn.ppn0 = 10'($urandom);
    e.mega = mega;
    e.exec = exec;
    return e;
endfunction

// megapages take vpn0 from the address instead of ppn0.
function automatic paddr_t phys_of(input tlb_entry_t e, input vaddr_t va);
    if (e.mega) begin
        return {e.ppn.ppn1, va[21:12], va[11:0]};
    end
    return {e.ppn.ppn1, e.ppn.ppn0, va[11:0]};
endfunction

function automatic logic [31:0] pte_addr(input vaddr_t va);
    return {10'b0, va[31:12], 2'b00};
endfunction

task automatic set_pte(input vaddr_t va, input tlb_entry_t e, input logic err);
    pte_table[va[31:12]] = e;
    err_table[va[31:12]] = err;
endtask

// drives both ports and waits until the result shows (hit or hold).
task automatic start_access(input logic r0, input vaddr_t va0, input logic r1,
                            input vaddr_t va1);
    int waited;
    walk_base = walk_log.size();
    @(negedge clk);
    req0 = r0;
    vaddr0 = va0;
    req1 = r1;
    vaddr1 = va1;
    ready = 1'b0;
    #1;
    first_miss = miss;
    waited = 0;
    while (miss && waited < WAIT_LIMIT) begin
        @(negedge clk);
        #1;
        waited++;
    end
    if (miss) begin
        errors++;
        $display("Translation still pending after %0d cycles at %0t", WAIT_LIMIT, $time);
    end
endtask

task automatic release_access();
    ready = 1'b1;
    @(negedge clk);
    req0 = 1'b0;
    req1 = 1'b0;
    ready = 1'b0;
    #1;
    check_miss(miss, 1'b0, "after release");
    check_fault(fault0, 1'b0, "port 0 after release");
    check_fault(fault1, 1'b0, "port 1 after release");
endtask

// ----------------------------------------------------------------------
// directed tests.
// ----------------------------------------------------------------------
task automatic test_cold_miss();
    vaddr_t va;
    tlb_entry_t e;
    va = make_va(10'h011, 10'($urandom), 12'($urandom));
    e = make_entry(1'b0, 1'b1);
    set_pte(va, e, 1'b0);
    start_access(1'b1, va, 1'b0, '0);
    check_miss(first_miss, 1'b1, "cold miss");
    check_walk_count(1, "cold miss");
    check_walk(walk_log[walk_base], pte_addr(va), "cold miss");
    // ready low keeps the result up.
    repeat (3) begin
        check_paddr(paddr0, phys_of(e, va), "cold miss port 0");
        check_fault(fault0, 1'b0, "cold miss port 0");
        check_miss(miss, 1'b0, "cold miss hold");
        @(negedge clk);
        #1;
    end
    release_access();
endtask

task automatic test_two_ports();
    vaddr_t va0;
    vaddr_t va1;
    tlb_entry_t e0;
    tlb_entry_t e1;
    va0 = make_va(10'h022, 10'($urandom), 12'($urandom));
    va1 = make_va(10'h023, 10'($urandom), 12'($urandom));
    e0 = make_entry(1'b0, 1'b1);
    e1 = make_entry(1'b0, 1'b1);
    set_pte(va0, e0, 1'b0);
    set_pte(va1, e1, 1'b0);
    start_access(1'b1, va0, 1'b1, va1);
    check_miss(first_miss, 1'b1, "two ports");
    check_walk_count(2, "two ports");
    check_walk(walk_log[walk_base], pte_addr(va0), "two ports first");
    check_walk(walk_log[walk_base + 1], pte_addr(va1), "two ports second");
    check_paddr(paddr0, phys_of(e0, va0), "two ports port 0");
    check_paddr(paddr1, phys_of(e1, va1), "two ports port 1");
    check_fault(fault0, 1'b0, "two ports port 0");
    check_fault(fault1, 1'b0, "two ports port 1");
    release_access();
endtask

task automatic test_repeat_hit();
    vaddr_t va;
    vaddr_t vb;
    vaddr_t vc;
    tlb_entry_t e;
    va = make_va(10'h033, 10'($urandom), 12'($urandom));
    vb = {va[31:12], 12'($urandom)};
    vc = {va[31:12], 12'($urandom)};
    e = make_entry(1'b0, 1'b1);
    set_pte(va, e, 1'b0);
    start_access(1'b1, va, 1'b0, '0);
    release_access();
    start_access(1'b1, vb, 1'b1, vc);
    check_miss(first_miss, 1'b0, "repeat hit");
    check_paddr(paddr0, phys_of(e, vb), "repeat hit port 0");
    check_paddr(paddr1, phys_of(e, vc), "repeat hit port 1");
    release_access();
    check_walk_count(0, "repeat hit");
endtask

task automatic test_faults();
    vaddr_t va0;
    vaddr_t va1;
    va0 = make_va(10'h044, 10'($urandom), 12'($urandom));
    va1 = make_va(10'h045, 10'($urandom), 12'($urandom));
    set_pte(va0, make_entry(1'b0, 1'b0), 1'b0);
    set_pte(va1, make_entry(1'b0, 1'b1), 1'b1);
    // the second pass walks again since faults are not kept.
    repeat (2) begin
        start_access(1'b1, va0, 1'b1, va1);
        check_walk_count(2, "faults");
        // only the hold keeps the faults visible while ready is low.
        repeat (2) begin
            check_fault(fault0, 1'b1, "no exec port 0");
            check_fault(fault1, 1'b1, "slave error port 1");
            check_miss(miss, 1'b0, "fault hold");
            @(negedge clk);
            #1;
        end
        release_access();
    end
endtask

task automatic test_megapage();
    vaddr_t va;
    vaddr_t vb;
    vaddr_t vc;
    tlb_entry_t e;
    va = make_va(10'h155, 10'($urandom), 12'($urandom));
    vb = make_va(10'h155, va[21:12] + 10'd1, 12'($urandom));
    vc = make_va(10'h155, va[21:12] + 10'd2, 12'($urandom));
    e = make_entry(1'b1, 1'b1);
    set_pte(va, e, 1'b0);
    start_access(1'b1, va, 1'b0, '0);
    check_walk_count(1, "megapage");
    check_paddr(paddr0, phys_of(e, va), "megapage walk");
    release_access();
    start_access(1'b1, vb, 1'b1, vc);
    check_miss(first_miss, 1'b0, "megapage hit");
    check_paddr(paddr0, phys_of(e, vb), "megapage port 0");
    check_paddr(paddr1, phys_of(e, vc), "megapage port 1");
    release_access();
    check_walk_count(0, "megapage hit");
endtask

task automatic test_flush();
    vaddr_t va;
    tlb_entry_t e;
    va = make_va(10'h066, 10'($urandom), 12'($urandom));
    e = make_entry(1'b0, 1'b1);
    set_pte(va, e, 1'b0);
    start_access(1'b1, va, 1'b0, '0);
    release_access();
    start_access(1'b1, va, 1'b0, '0);
    check_miss(first_miss, 1'b0, "before flush");
    release_access();
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    start_access(1'b1, va, 1'b0, '0);
    check_miss(first_miss, 1'b1, "after flush");
    check_walk_count(1, "after flush");
    check_walk(walk_log[walk_base], pte_addr(va), "after flush");
    check_paddr(paddr0, phys_of(e, va), "after flush");
    release_access();
endtask

/* bench/itlb_tb.sv */
`timescale 1ns/1ns

module itlb_tb import itlb_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int WAIT_LIMIT = 50;

    logic clk;
    logic rst;
    logic req0;
    vaddr_t vaddr0;
    logic req1;
    vaddr_t vaddr1;
    logic ready;
    logic flush;
    logic miss;
    paddr_t paddr0;
    paddr_t paddr1;
    logic fault0;
    logic fault1;
    logic psel;
    logic penable;
    logic [31:0] paddr;
    logic pready = 1'b0;
    tlb_entry_t prdata = '0;
    logic pslverr = 1'b0;

    int checks = 0;
    int errors = 0;
    int cycle_count = 0;
    logic first_miss;

    // l2 tlb contents, keyed by vpn.
    tlb_entry_t pte_table [logic [19:0]];
    logic err_table [logic [19:0]];
    logic [31:0] walk_log [$];
    int walk_base = 0;
    int wait_left = 0;
    logic [19:0] key;

    itlb_top #(.ENTRIES(8)) dut0 (
        .clk     (clk),
        .rst     (rst),
        .req0    (req0),
        .vaddr0  (vaddr0),
        .req1    (req1),
        .vaddr1  (vaddr1),
        .ready   (ready),
        .flush   (flush),
        .miss    (miss),
        .paddr0  (paddr0),
        .paddr1  (paddr1),
        .fault0  (fault0),
        .fault1  (fault1),
        .psel    (psel),
        .penable (penable),
        .paddr   (paddr),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // apb completer with 0 to 3 wait states.
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (psel && penable && !pready) begin
            if (wait_left == 0) begin
                key = paddr[21:2];
                pready <= 1'b1;
                prdata <= pte_table.exists(key) ? pte_table[key] : '0;
                pslverr <= err_table.exists(key) ? err_table[key] : 1'b0;
                walk_log.push_back(paddr);
            end else begin
                wait_left <= wait_left - 1;
            end
        end else begin
            pready <= 1'b0;
            if (psel && !penable) begin
                wait_left <= int'($urandom_range(3, 0));
            end
        end
    end

    // ----------------------------------------------------------------------
    // compare tasks.
    // ----------------------------------------------------------------------
    task automatic check_paddr(input paddr_t got, input paddr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s paddr is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_fault(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s fault is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_miss(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s miss is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_walk(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s walk address is %h, expected %h",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_walk_count(input int n, input string what);
        checks++;
        if (walk_log.size() - walk_base != n) begin
            errors++;
            $display("Error at %0t: %s saw %0d walks, expected %0d",
                     $time, what, walk_log.size() - walk_base, n);
        end
    endtask

    `include "itlb_tests.svh"

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(83236));
        rst = 1'b1;
        req0 = 1'b0;
        vaddr0 = '0;
        req1 = 1'b0;
        vaddr1 = '0;
        ready = 1'b0;
        flush = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_cold_miss();
        test_two_ports();
        test_repeat_hit();
        test_faults();
        test_megapage();
        test_flush();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog/itlb_top.sv */
`timescale 1ns/1ns

module itlb_top import itlb_pkg::*; #(
    parameter int ENTRIES = 8
) (
    input  logic clk,
    input  logic rst,

    // fetch side.
    input  logic req0,
    input  vaddr_t vaddr0,
    input  logic req1,
    input  vaddr_t vaddr1,
    input  logic ready,
    input  logic flush,
    output logic miss,
    output paddr_t paddr0,
    output paddr_t paddr1,
    output logic fault0,
    output logic fault1,

    // l2 tlb over apb.
    output logic psel,
    output logic penable,
    output logic [31:0] paddr,
    input  logic pready,
    input  tlb_entry_t prdata,
    input  logic pslverr
);

    tlb_lookup_if lk0_if ();
    tlb_lookup_if lk1_if ();
    tlb_fill_if fill_if ();

    // both arrays see the same refills, so they hold the same pages.
    tlb_array #(.ENTRIES(ENTRIES)) arr0 (
        .clk  (clk),
        .rst  (rst),
        .look (lk0_if.array),
        .fill (fill_if.sink)
    );

    tlb_array #(.ENTRIES(ENTRIES)) arr1 (
        .clk  (clk),
        .rst  (rst),
        .look (lk1_if.array),
        .fill (fill_if.sink)
    );

    itlb_miss_unit #(.ENTRIES(ENTRIES)) miss0 (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .ready   (ready),
        .miss    (miss),
        .fault0  (fault0),
        .fault1  (fault1),
        .paddr0  (paddr0),
        .paddr1  (paddr1),
        .req0    (req0),
        .req1    (req1),
        .vaddr0  (vaddr0),
        .vaddr1  (vaddr1),
        .lk0     (lk0_if.miss),
        .lk1     (lk1_if.miss),
        .fill    (fill_if.source),
        .psel    (psel),
        .penable (penable),
        .paddr   (paddr),
        .pready  (pready),
        .pslverr (pslverr),
        .prdata  (prdata)
    );

endmodule

/* verilog/itlb_miss_unit.sv */
`timescale 1ns/1ns

module itlb_miss_unit import itlb_pkg::*; #(
    parameter int ENTRIES = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic ready,
    output logic miss,
    output logic fault0,
    output logic fault1,
    output paddr_t paddr0,
    output paddr_t paddr1,
    input  logic req0,
    input  logic req1,
    input  vaddr_t vaddr0,
    input  vaddr_t vaddr1,
    tlb_lookup_if.miss lk0,
    tlb_lookup_if.miss lk1,
    tlb_fill_if.source fill,
    output logic psel,
    output logic penable,
    output logic [31:0] paddr,
    input  logic pready,
    input  logic pslverr,
    input  tlb_entry_t prdata
);

    localparam int IW = $clog2(ENTRIES);

    miss_state_t state_q;
    logic [1:0] need_q;
    logic [1:0] fault_q;
    vaddr_t va_q [2];
    paddr_t res_q [2];
    logic [7:0] lfsr_q;
    logic psel_q;
    logic penable_q;
    logic [31:0] paddr_q;

    logic idle;
    logic hold;
    logic [1:0] port_miss;
    logic start;
    logic done;
    logic take;
    logic next_walk;
    logic port_sel;
    vaddr_t walk_va;
    vpn_t walk_vpn;
    logic walk_fault;
    paddr_t walk_paddr;

    function automatic logic [31:0] walk_addr(vaddr_t va);
        return 32'(va[VADDR_W-1:OFF_W]) << PTE_ADDR_SHIFT;
    endfunction

    assign idle = (state_q == IDLE);
    assign hold = (state_q == HOLD);

    // live addresses while idle, latched ones during a walk.
    assign lk0.req = idle & req0;
    assign lk0.vaddr = idle ? vaddr0 : va_q[0];
    assign lk1.req = idle ? req1 : need_q[1];
    assign lk1.vaddr = idle ? vaddr1 : va_q[1];

    assign port_miss = {lk1.req & ~lk1.hit, lk0.req & ~lk0.hit};
    // a dropped transfer may still be on the bus after flush.
    assign start = idle & (|port_miss) & ~psel_q & ~flush;

    // ----------------------------------------------------------------------
    // walk completion.
    // ----------------------------------------------------------------------
    assign done = psel_q & penable_q & pready;
    assign take = done & ~flush & (state_q == WALK_PORT0 || state_q == WALK_PORT1);
    assign next_walk = take & (state_q == WALK_PORT0) & need_q[1];
    assign port_sel = (state_q == WALK_PORT1);

    assign walk_va = port_sel ? va_q[1] : va_q[0];
    assign walk_vpn = vpn_t'(walk_va[VADDR_W-1:OFF_W]);
    assign walk_fault = pslverr | ~prdata.exec;
    assign walk_paddr = {
        prdata.ppn.ppn1,
        prdata.mega ? walk_vpn.vpn0 : prdata.ppn.ppn0,
        walk_va[OFF_W-1:0]
    };

    // port 1 may already be covered by the entry port 0 just wrote.
    assign fill.we = take & ~walk_fault & ~(port_sel & lk1.hit);
    assign fill.widx = idx_t'(lfsr_q[IW-1:0]);
    assign fill.wvpn = walk_vpn;
    assign fill.wentry = prdata;
    assign fill.flush = flush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            need_q <= '0;
            fault_q <= '0;
        end else if (flush) begin
            state_q <= IDLE;
            need_q <= '0;
            fault_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start) begin
                        need_q <= port_miss;
                        fault_q <= {lk1.hit & ~lk1.exec, lk0.hit & ~lk0.exec};
                        state_q <= port_miss[0] ? WALK_PORT0 : WALK_PORT1;
                    end
                end
                WALK_PORT0: begin
                    if (take) begin
                        fault_q[0] <= walk_fault;
                        state_q <= need_q[1] ? WALK_PORT1 : HOLD;
                    end
                end
                WALK_PORT1: begin
                    if (take) begin
                        fault_q[1] <= walk_fault;
                        state_q <= HOLD;
                    end
                end
                HOLD: begin
                    if (ready) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // apb requester.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            psel_q <= 1'b0;
            penable_q <= 1'b0;
        end else if (start) begin
            psel_q <= 1'b1;
            penable_q <= 1'b0;
        end else if (done) begin
            // back to back setup for port 1.
            psel_q <= next_walk;
            penable_q <= 1'b0;
        end else if (psel_q) begin
            penable_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            va_q[0] <= vaddr0;
            va_q[1] <= vaddr1;
            res_q[0] <= lk0.paddr;
            res_q[1] <= lk1.paddr;
            paddr_q <= walk_addr(port_miss[0] ? vaddr0 : vaddr1);
        end else begin
            if (take) begin
                res_q[port_sel] <= walk_paddr;
            end
            if (next_walk) begin
                paddr_q <= walk_addr(va_q[1]);
            end
        end
    end

    // x^8 + x^6 + x^5 + x^4 + 1.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_q <= 8'h01;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    assign psel = psel_q;
    assign penable = penable_q;
    assign paddr = paddr_q;

    assign miss = idle ? (|port_miss) : ~hold;
    assign paddr0 = hold ? res_q[0] : lk0.paddr;
    assign paddr1 = hold ? res_q[1] : lk1.paddr;
    assign fault0 = hold ? fault_q[0] : (lk0.req & lk0.hit & ~lk0.exec);
    assign fault1 = hold ? fault_q[1] : (idle & lk1.req & lk1.hit & ~lk1.exec);

    // the completer may stall; the request must not move under it.
    a_apb_hold: assert property (
        @(posedge clk) disable iff (rst)
        psel_q && !(penable_q && pready) |=> psel_q && $stable(paddr_q)
    ) else $error("apb request changed before pready");

    a_apb_enable: assert property (
        @(posedge clk) disable iff (rst)
        penable_q |-> psel_q
    ) else $error("penable without psel");

endmodule

/* verilog/tlb_array.sv */
`timescale 1ns/1ns

module tlb_array import itlb_pkg::*; #(
    parameter int ENTRIES = 8
) (
    input  logic clk,
    input  logic rst,
    tlb_lookup_if.array look,
    tlb_fill_if.sink fill
);

    localparam int IW = $clog2(ENTRIES);

    logic [ENTRIES-1:0] valid_q;
    vpn_t tag_q [ENTRIES];
    tlb_entry_t data_q [ENTRIES];

    logic [ENTRIES-1:0] match;
    vpn_t look_vpn;
    page_off_t look_off;
    tlb_entry_t hit_entry;
    logic [IW-1:0] wslot;

    // ----------------------------------------------------------------------
    // lookup.
    // ----------------------------------------------------------------------
    assign look_vpn = vpn_t'(look.vaddr[VADDR_W-1:OFF_W]);
    assign look_off = look.vaddr[OFF_W-1:0];

    // megapages compare the upper half only.
    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            match[i] = valid_q[i]
                && (tag_q[i].vpn1 == look_vpn.vpn1)
                && (data_q[i].mega || (tag_q[i].vpn0 == look_vpn.vpn0));
        end
    end

    // at most one slot matches, so a plain priority pick is enough.
    always_comb begin
        hit_entry = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (match[i]) begin
                hit_entry = data_q[i];
            end
        end
    end

    assign look.hit = look.req & (|match);
    assign look.exec = hit_entry.exec;
    assign look.paddr = {
        hit_entry.ppn.ppn1,
        hit_entry.mega ? look_vpn.vpn0 : hit_entry.ppn.ppn0,
        look_off
    };

    // ----------------------------------------------------------------------
    // refill and flush.
    // ----------------------------------------------------------------------
    assign wslot = fill.widx[IW-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill.flush) begin
            valid_q <= '0;
        end else if (fill.we) begin
            valid_q[wslot] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.we && !fill.flush) begin
            tag_q[wslot] <= fill.wvpn;
            data_q[wslot] <= fill.wentry;
        end
    end

    // ----------------------------------------------------------------------
    // checks.
    // ----------------------------------------------------------------------

    // the miss unit only refills pages that missed, so no page is held twice.
    a_one_match: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(match)
    ) else $error("more than one slot matches the lookup");

    // victim index comes from the miss unit and must fit this array.
    a_widx_range: assert property (
        @(posedge clk) disable iff (rst)
        fill.we |-> (int'(fill.widx) < ENTRIES)
    ) else $error("refill index out of range");

endmodule

/* verilog/tlb_fill_if.sv */
`timescale 1ns/1ns

// refill and flush, shared by both arrays.
interface tlb_fill_if import itlb_pkg::*; ();

    logic we;
    idx_t widx;
    vpn_t wvpn;
    tlb_entry_t wentry;
    logic flush;

    modport source (
        output we, widx, wvpn, wentry, flush
    );

    modport sink (
        input  we, widx, wvpn, wentry, flush
    );

endinterface

/* verilog/tlb_lookup_if.sv */
`timescale 1ns/1ns

// one fetch port's lookup into one array, answered in the same cycle.
interface tlb_lookup_if import itlb_pkg::*; ();

    logic req;
    vaddr_t vaddr;
    logic hit;
    paddr_t paddr;
    logic exec;

    modport array (
        input  req, vaddr,
        output hit, paddr, exec
    );

    modport miss (
        output req, vaddr,
        input  hit, paddr, exec
    );

endinterface

/* verilog/itlb_pkg.sv */
package itlb_pkg;

    // ----------------------------------------------------------------------
    // sv32 field widths.
    // ----------------------------------------------------------------------
    localparam int VADDR_W = 32;
    localparam int PADDR_W = 34;
    localparam int OFF_W = 12;
    localparam int VPN_HALF_W = 10;
    localparam int PPN1_W = 12;
    localparam int PPN0_W = 10;
    localparam int PPN_W = PPN1_W + PPN0_W;

    // an entry is exactly one apb read word.
    localparam int ENTRY_W = 32;
    localparam int ENTRY_RSVD_W = ENTRY_W - PPN_W - 2;

    // the refill index field is sized for the largest array.
    localparam int MAX_ENTRIES = 32;
    localparam int IDX_W = $clog2(MAX_ENTRIES);

    // walk address is the vpn scaled to a word address.
    localparam int PTE_ADDR_SHIFT = 2;

    typedef logic [VADDR_W-1:0] vaddr_t;
    typedef logic [PADDR_W-1:0] paddr_t;
    typedef logic [OFF_W-1:0] page_off_t;
    typedef logic [VPN_HALF_W-1:0] vpn_half_t;
    typedef logic [IDX_W-1:0] idx_t;

    typedef struct packed {
        vpn_half_t vpn1;
        vpn_half_t vpn0;
    } vpn_t;

    typedef struct packed {
        logic [PPN1_W-1:0] ppn1;
        logic [PPN0_W-1:0] ppn0;
    } ppn_t;

    // mega set means ppn0 is ignored and vpn0 passes through.
    typedef struct packed {
        ppn_t ppn;
        logic mega;
        logic exec;
        logic [ENTRY_RSVD_W-1:0] rsvd;
    } tlb_entry_t;

    // ----------------------------------------------------------------------
    // miss handling.
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE,
        WALK_PORT0,
        WALK_PORT1,
        HOLD
    } miss_state_t;

endpackage
